/* design/raster_geom_pkg.sv */
package raster_geom_pkg;

	// column coordinate, wide enough for 640 columns
	localparam int col_w = 10;

	// row coordinate, wide enough for 480 rows
	localparam int row_w = 9;

	typedef logic [col_w-1:0] col_t;
	typedef logic [row_w-1:0] row_t;

	// position of one pixel in the frame, col in the upper bits
	typedef struct packed {
		col_t col;
		row_t row;
	} pixel_coord_t;

	// top left corner, where every frame starts
	localparam pixel_coord_t coord_origin = '{
		col: '0,
		row: '0
	};

endpackage

/* design/pattern_pkg.sv */
package pattern_pkg;

	import raster_geom_pkg::*;

	// 3-bit color index as taken by the frame-buffer writer
	typedef logic [2:0] color_t;

	// pattern kinds, stepped in this order on every color wrap
	typedef enum logic [1:0] {
		pat_solid    = 2'd0,
		pat_bars     = 2'd1,
		pat_checker  = 2'd2,
		pat_gradient = 2'd3
	} pattern_e;

	// drawing mode, constant over a run of frames
	typedef struct packed {
		pattern_e pattern;
		color_t   color;
	} frame_mode_t;

	// color shown after reset
	localparam color_t reset_color = 3'd2;

	// top color value before the index wraps to 0
	localparam color_t max_color = 3'd7;

	// one shaded pixel as presented to the reader
	typedef struct packed {
		pixel_coord_t coord;
		color_t       color;
	} pixel_out_t;

endpackage

/* design/pixel_scan.sv */
module pixel_scan import raster_geom_pkg::*; #(
	parameter int h_active = 640,
	parameter int v_active = 480
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         read_rdy,
	output pixel_coord_t coord,
	output logic         frame_end
);

	localparam col_t last_col = col_w'(h_active - 1);
	localparam row_t last_row = row_w'(v_active - 1);

	col_t col;
	row_t row;
	logic at_line_end;
	logic at_frame_end;

	// position of the pixel currently presented
	assign at_line_end  = (col == last_col);
	assign at_frame_end = at_line_end && (row == last_row);

	// last pixel of the frame taken this cycle
	assign frame_end = read_rdy && at_frame_end;

	assign coord.col = col;
	assign coord.row = row;

	// column counter, wraps at every line end
	always_ff @(posedge clk) begin
		if (rst) begin
			col <= coord_origin.col;
		end else if (read_rdy) begin
			if (at_line_end) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// row counter, steps once per line and wraps at the frame end
	always_ff @(posedge clk) begin
		if (rst) begin
			row <= coord_origin.row;
		end else if (read_rdy && at_line_end) begin
			if (at_frame_end) begin
				row <= '0;
			end else begin
				row <= row + 1'b1;
			end
		end
	end

endmodule

/* design/frame_sequencer.sv */
module frame_sequencer import pattern_pkg::*; #(
	parameter int hold_frames = 60
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        frame_end,
	output frame_mode_t mode,
	output logic        frame_switch
);

	// count 0 .. hold_frames-1, at least one bit wide
	localparam int cnt_w = (hold_frames > 1) ? $clog2(hold_frames) : 1;
	localparam logic [cnt_w-1:0] last_count = cnt_w'(hold_frames - 1);

	logic [cnt_w-1:0] frame_cnt;
	frame_mode_t      next_mode;

	// kinds cycle solid, bars, checker, gradient and back to solid
	function automatic pattern_e next_pattern(input pattern_e cur);
		pattern_e nxt;
		case (cur)
			pat_solid:   nxt = pat_bars;
			pat_bars:    nxt = pat_checker;
			pat_checker: nxt = pat_gradient;
			default:     nxt = pat_solid;
		endcase
		return nxt;
	endfunction

	// strobe on the last pixel of every hold_frames-th frame
	assign frame_switch = frame_end && (frame_cnt == last_count);

	// mode after the next switch
	always_comb begin
		next_mode       = mode;
		next_mode.color = mode.color + 3'd1;
		// color wraps from 7 to 0, so move on to the next kind
		if (mode.color == max_color) begin
			next_mode.pattern = next_pattern(mode.pattern);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_cnt    <= '0;
			mode.pattern <= pat_solid;
			mode.color   <= reset_color;
		end else if (frame_switch) begin
			frame_cnt <= '0;
			mode      <= next_mode;
		end else if (frame_end) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

endmodule

/* design/pattern_shader.sv */
module pattern_shader
	import raster_geom_pkg::*;
	import pattern_pkg::*;
(
	input  pixel_coord_t coord,
	input  frame_mode_t  mode,
	output pixel_out_t   pixel
);

	color_t bar_color;
	logic   checker_even;
	color_t checker_color;
	color_t grad_color;
	color_t shade;

	// bars 16 columns wide, the XOR gives a new color per bar
	assign bar_color = mode.color ^ coord.col[6:4];

	// 8x8 squares, odd squares show the inverted color
	assign checker_even  = (coord.col[3] == coord.row[3]);
	assign checker_color = checker_even ? mode.color : ~mode.color;

	// color steps every 8 rows, wrapping mod 8
	assign grad_color = mode.color + coord.row[5:3];

	always_comb begin
		case (mode.pattern)
			pat_solid: begin
				shade = mode.color;
			end
			pat_bars: begin
				shade = bar_color;
			end
			pat_checker: begin
				shade = checker_color;
			end
			pat_gradient: begin
				shade = grad_color;
			end
			default: begin
				shade = mode.color;
			end
		endcase
	end

	// coordinate goes out unchanged beside its color
	always_comb begin
		pixel       = '0;
		pixel.coord = coord;
		pixel.color = shade;
	end

endmodule

/* design/test_pattern_source.sv */
module test_pattern_source
	import raster_geom_pkg::*;
	import pattern_pkg::*;
#(
	parameter int h_active    = 640,
	parameter int v_active    = 480,
	parameter int hold_frames = 60
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       read_rdy,
	output pixel_out_t pixel,
	output logic       pixel_rdy,
	output logic       frame_switch
);

	pixel_coord_t coord;
	logic         frame_end;
	frame_mode_t  mode;

	// a pixel is always on offer once out of reset
	assign pixel_rdy = !rst;

	// raster position, steps on every accepted pixel
	pixel_scan #(
		.h_active (h_active),
		.v_active (v_active)
	) u_scan (
		.clk       (clk),
		.rst       (rst),
		.read_rdy  (read_rdy),
		.coord     (coord),
		.frame_end (frame_end)
	);

	// drawing mode, changes after every hold_frames frames
	frame_sequencer #(
		.hold_frames (hold_frames)
	) u_seq (
		.clk          (clk),
		.rst          (rst),
		.frame_end    (frame_end),
		.mode         (mode),
		.frame_switch (frame_switch)
	);

	pattern_shader u_shader (
		.coord (coord),
		.mode  (mode),
		.pixel (pixel)
	);

endmodule

/* dv/test_pattern_source_chk.sv */
module test_pattern_source_chk
	import raster_geom_pkg::*;
	import pattern_pkg::*;
#(
	parameter int h_active = 640,
	parameter int v_active = 480
) (
	input logic       clk,
	input logic       rst,
	input logic       read_rdy,
	input pixel_out_t pixel,
	input logic       frame_switch
);

	localparam col_t col_limit = col_w'(h_active);
	localparam row_t row_limit = row_w'(v_active);

	// presented pixel always inside the active area
	coord_in_range: assert property (
		@(posedge clk) disable iff (rst)
		(pixel.coord.col < col_limit) && (pixel.coord.row < row_limit)
	) else $error("coordinate outside the active area");

	// a stalled reader sees the same pixel next cycle
	stall_holds_pixel: assert property (
		@(posedge clk) disable iff (rst)
		!read_rdy |=> $stable(pixel.coord) && $stable(pixel.color)
	) else $error("pixel changed while read_rdy was low");

	switch_needs_ready: assert property (
		@(posedge clk) disable iff (rst)
		frame_switch |-> read_rdy
	) else $error("frame_switch without read_rdy");

	// new mode starts at the top left corner
	switch_then_origin: assert property (
		@(posedge clk) disable iff (rst)
		frame_switch |=> (pixel.coord == coord_origin)
	) else $error("frame_switch not followed by coordinate (0,0)");

endmodule

/* dv/tb_test_pattern_source.sv */
module tb_test_pattern_source
	import raster_geom_pkg::*;
	import pattern_pkg::*;
();

	// small frame so that many frames fit in one run
	localparam int h_act        = 16;
	localparam int v_act        = 12;
	localparam int hold         = 2;
	localparam int half_period  = 50;
	localparam int reset_cycles = 16;
	localparam int margin       = 200;
	localparam int n_entries    = 5;

	// cycles to run and ready density in eighths for one stimulus step
	typedef struct packed {
		logic [15:0] cycles;
		logic [3:0]  density;
	} stim_entry_t;

	localparam stim_entry_t stim_table [n_entries] = '{
		'{16'd6000, 4'd8},
		'{16'd200,  4'd0},
		'{16'd4000, 4'd5},
		'{16'd2000, 4'd1},
		'{16'd8000, 4'd8}
	};

	logic       clk;
	logic       rst;
	logic       read_rdy;
	pixel_out_t pixel;
	logic       pixel_rdy;
	logic       frame_switch;

	logic [31:0] lfsr_state;

	// reference model state
	col_t        model_col;
	row_t        model_row;
	int          model_cnt;
	frame_mode_t model_mode;
	logic [3:0]  patterns_seen;
	int          switch_count;

	test_pattern_source #(
		.h_active    (h_act),
		.v_active    (v_act),
		.hold_frames (hold)
	) u_test_pattern_source (
		.clk          (clk),
		.rst          (rst),
		.read_rdy     (read_rdy),
		.pixel        (pixel),
		.pixel_rdy    (pixel_rdy),
		.frame_switch (frame_switch)
	);

	bind test_pattern_source test_pattern_source_chk #(
		.h_active (h_active),
		.v_active (v_active)
	) u_chk (
		.clk          (clk),
		.rst          (rst),
		.read_rdy     (read_rdy),
		.pixel        (pixel),
		.frame_switch (frame_switch)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(half_period) clk = ~clk;
		end
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		logic [31:0] nxt;
		nxt = s >> 1;
		if (s[0]) begin
			nxt = nxt ^ 32'h8020_0003;
		end
		return nxt;
	endfunction

	task automatic draw_ready_bits(output logic [2:0] bits);
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			bits       = {bits[1:0], lfsr_state[0]};
			lfsr_state = lfsr_advance(lfsr_state);
		end
	endtask

	// color rule per pattern kind
	function automatic color_t expected_shade(input pixel_coord_t c, input frame_mode_t m);
		color_t s;
		s = m.color;
		if (m.pattern == pat_bars) begin
			s = m.color ^ c.col[6:4];
		end else if (m.pattern == pat_checker) begin
			if (c.col[3] ^ c.row[3]) begin
				s = ~m.color;
			end
		end else if (m.pattern == pat_gradient) begin
			s = m.color + c.row[5:3];
		end
		return s;
	endfunction

	function automatic pixel_out_t expected_pixel();
		pixel_out_t p;
		p.coord.col = model_col;
		p.coord.row = model_row;
		p.color     = expected_shade(p.coord, model_mode);
		return p;
	endfunction

	function automatic logic expected_switch(input logic rdy);
		logic last_pixel;
		last_pixel = (model_col == col_w'(h_act - 1)) && (model_row == row_w'(v_act - 1));
		return rdy && last_pixel && (model_cnt == hold - 1);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_pixel(input pixel_out_t got, input pixel_out_t exp);
		if (got !== exp) begin
			fail_run($sformatf(
				"Fail at %0t: pixel col %0d row %0d color %0d, expected col %0d row %0d color %0d",
				$time, got.coord.col, got.coord.row, got.color,
				exp.coord.col, exp.coord.row, exp.color));
		end
	endtask

	task automatic check_switch(input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Fail at %0t: frame_switch is %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic check_ready_level(input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Fail at %0t: pixel_rdy is %b, expected %b",
				$time, got, exp));
		end
	endtask

	// model step for one accepted pixel
	task automatic advance_model();
		if (model_col != col_w'(h_act - 1)) begin
			model_col = model_col + 1'b1;
		end else begin
			model_col = '0;
			if (model_row != row_w'(v_act - 1)) begin
				model_row = model_row + 1'b1;
			end else begin
				model_row = '0;
				if (model_cnt == hold - 1) begin
					model_cnt = 0;
					// color wrap moves on to the next kind
					if (model_mode.color == 3'd7) begin
						model_mode.pattern = pattern_e'(model_mode.pattern + 2'd1);
					end
					model_mode.color = model_mode.color + 3'd1;
				end else begin
					model_cnt = model_cnt + 1;
				end
			end
		end
	endtask

	// drive on the falling edge, compare shortly before the rising edge
	task automatic run_cycle(input logic [3:0] density);
		logic [2:0] bits;
		logic       rdy;
		logic       exp_sw;
		@(negedge clk);
		draw_ready_bits(bits);
		rdy      = ({1'b0, bits} < density);
		read_rdy = rdy;
		#(half_period - 10);
		exp_sw = expected_switch(rdy);
		check_pixel(pixel, expected_pixel());
		check_switch(frame_switch, exp_sw);
		check_ready_level(pixel_rdy, 1'b1);
		patterns_seen[model_mode.pattern] = 1'b1;
		if (exp_sw) begin
			switch_count = switch_count + 1;
		end
		if (rdy) begin
			advance_model();
		end
	endtask

	initial begin
		rst           = 1'b1;
		read_rdy      = 1'b0;
		lfsr_state    = 32'ha07c_6330;
		model_col     = '0;
		model_row     = '0;
		model_cnt     = 0;
		model_mode    = '{pattern: pat_solid, color: 3'd2};
		patterns_seen = '0;
		switch_count  = 0;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		check_ready_level(pixel_rdy, 1'b0);
		rst = 1'b0;
		#(half_period - 10);

		// state right after reset
		check_pixel(pixel, expected_pixel());
		check_switch(frame_switch, 1'b0);
		check_ready_level(pixel_rdy, 1'b1);

		for (int e = 0; e < n_entries; e++) begin
			for (int c = 0; c < int'(stim_table[e].cycles); c++) begin
				run_cycle(stim_table[e].density);
			end
		end

		$display("%0d frame switches checked", switch_count);
		if (patterns_seen == 4'b1111) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_run("the run ended before every pattern kind was reached");
		end
	end

	// watchdog sized from the stimulus table
	initial begin
		int limit_cycles;
		limit_cycles = reset_cycles + margin;
		for (int e = 0; e < n_entries; e++) begin
			limit_cycles = limit_cycles + int'(stim_table[e].cycles);
		end
		#(limit_cycles * 2 * half_period);
		fail_run("watchdog expired before the test sequence finished");
	end

endmodule

/* filelist.f */
design/raster_geom_pkg.sv
design/pattern_pkg.sv
design/pixel_scan.sv
design/frame_sequencer.sv
design/pattern_shader.sv
design/test_pattern_source.sv
dv/test_pattern_source_chk.sv
dv/tb_test_pattern_source.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the test pattern source testbench with Verilator.
# Exits non-zero if the build fails, the simulation fails, or the pass
# message is missing from the simulation output.

set -u

cd "$(dirname "$0")"

top=tb_test_pattern_source
build_dir=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module "$top" \
	-Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$("./$build_dir/V$top" 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" <<< "$output"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi
